/* axi_pkg.sv */
package axi_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // byte offset bits inside one data word
  localparam int byte_off_w = $clog2(strb_w);

  // address map
  // everything below this goes to the clint
  localparam logic [addr_w-1:0] clint_limit = 32'h0200_ffff;

  // sram depth in words, index wraps modulo depth
  localparam int sram_words = 256;
  localparam int sram_idx_w = $clog2(sram_words);

  // largest arlen served, i.e. 4 beats
  localparam logic [7:0] max_burst_len = 8'd3;

  // axi burst encodings, only incr is served
  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } axi_burst_t;

  // read grant of the arbiter
  typedef enum logic [1:0] {
    xbar_idle,
    xbar_ifu_read,
    xbar_lsu_read
  } xbar_state_t;

  // sram slave state
  typedef enum logic [1:0] {
    sram_idle,
    sram_read_burst,
    sram_write_resp
  } sram_state_t;

  // read channel, master to slave (ar plus rready)
  typedef struct packed {
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic [7:0]        arlen;
    logic [2:0]        arsize;
    axi_burst_t        arburst;
    logic              rready;
  } axi_r_m2s_t;

  // read channel, slave to master
  typedef struct packed {
    logic              arready;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic              rlast;
  } axi_r_s2m_t;

  // write channel, master to slave (aw, w and bready)
  typedef struct packed {
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic [7:0]        awlen;
    logic [2:0]        awsize;
    axi_burst_t        awburst;
    logic              wvalid;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              wlast;
    logic              bready;
  } axi_w_m2s_t;

  // write channel, slave to master
  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
  } axi_w_s2m_t;

endpackage

/* clint.sv */
`timescale 1ns/10ps

module clint
  import axi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  axi_r_m2s_t r_m2s,
  output axi_r_s2m_t r_s2m
);

  logic [63:0]       mtime_q;
  logic              rvalid_q;
  logic [data_w-1:0] rdata_q;
  logic              ar_fire;
  logic              r_fire;

  // free running timer
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // one response in flight at most
  assign ar_fire = r_m2s.arvalid && !rvalid_q;
  assign r_fire  = rvalid_q && r_m2s.rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (r_fire) begin
      rvalid_q <= 1'b0;
    end
  end

  // offset 4 picks the high word, sampled at the ar transfer
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata_q <= r_m2s.araddr[2] ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign r_s2m.arready = !rvalid_q;
  assign r_s2m.rvalid  = rvalid_q;
  assign r_s2m.rdata   = rdata_q;
  // always a single beat
  assign r_s2m.rlast   = 1'b1;

endmodule

/* axi_sram.sv */
`timescale 1ns/10ps

module axi_sram
  import axi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  axi_r_m2s_t r_m2s,
  output axi_r_s2m_t r_s2m,
  input  axi_w_m2s_t w_m2s,
  output axi_w_s2m_t w_s2m
);

  logic [data_w-1:0] mem [sram_words];

  sram_state_t       state_q;
  logic [sram_idx_w-1:0] addr_q;
  logic [7:0]        beat_q;
  logic [7:0]        len_q;
  logic [data_w-1:0] rdata_q;

  logic [sram_idx_w-1:0] ar_idx;
  logic [sram_idx_w-1:0] aw_idx;
  logic [sram_idx_w-1:0] next_idx;
  logic [7:0]        ar_len;
  logic              last_beat;
  logic              ar_fire;
  logic              r_fire;
  logic              w_fire;
  logic              b_fire;

  // word index wraps modulo depth
  assign ar_idx   = r_m2s.araddr[byte_off_w +: sram_idx_w];
  assign aw_idx   = w_m2s.awaddr[byte_off_w +: sram_idx_w];
  assign next_idx = addr_q + 1'b1;

  // incr bursts clamped to 4 beats, other burst types get one beat
  assign ar_len = (r_m2s.arburst != burst_incr) ? 8'd0 :
                  (r_m2s.arlen > max_burst_len) ? max_burst_len : r_m2s.arlen;

  assign last_beat = beat_q == len_q;

  // read has priority over write in idle
  assign r_s2m.arready = state_q == sram_idle;
  assign w_s2m.awready = (state_q == sram_idle) && !r_m2s.arvalid &&
                         w_m2s.awvalid && w_m2s.wvalid;
  assign w_s2m.wready  = w_s2m.awready;

  assign ar_fire = r_m2s.arvalid && r_s2m.arready;
  assign r_fire  = r_s2m.rvalid && r_m2s.rready;
  assign w_fire  = w_s2m.awready;
  assign b_fire  = w_s2m.bvalid && w_m2s.bready;

  // control fsm
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= sram_idle;
      addr_q  <= '0;
      beat_q  <= '0;
      len_q   <= '0;
    end else begin
      unique case (state_q)
        sram_idle: begin
          if (ar_fire) begin
            state_q <= sram_read_burst;
            addr_q  <= ar_idx;
            beat_q  <= '0;
            len_q   <= ar_len;
          end else if (w_fire) begin
            state_q <= sram_write_resp;
          end
        end
        sram_read_burst: begin
          if (r_fire) begin
            if (last_beat) begin
              state_q <= sram_idle;
            end else begin
              // next beat, incr only
              addr_q <= next_idx;
              beat_q <= beat_q + 8'd1;
            end
          end
        end
        sram_write_resp: begin
          if (b_fire) begin
            state_q <= sram_idle;
          end
        end
        default: begin
          state_q <= sram_idle;
        end
      endcase
    end
  end

  // read data register, holds under back-pressure
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata_q <= mem[ar_idx];
    end else if (r_fire && !last_beat) begin
      rdata_q <= mem[next_idx];
    end
  end

  // storage, zeroed at reset so unwritten words read as known
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < sram_words; i++) begin
        mem[i] <= '0;
      end
    end else if (w_fire) begin
      // byte lanes under strobe
      for (int b = 0; b < strb_w; b++) begin
        if (w_m2s.wstrb[b]) begin
          mem[aw_idx][b*8 +: 8] <= w_m2s.wdata[b*8 +: 8];
        end
      end
    end
  end

  assign r_s2m.rvalid = state_q == sram_read_burst;
  assign r_s2m.rdata  = rdata_q;
  assign r_s2m.rlast  = last_beat;
  assign w_s2m.bvalid = state_q == sram_write_resp;

endmodule

/* axi_interconnect.sv */
`timescale 1ns/10ps

module axi_interconnect
  import axi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  input  axi_r_m2s_t ifu_r_m2s,
  output axi_r_s2m_t ifu_r_s2m,

  input  axi_r_m2s_t lsu_r_m2s,
  output axi_r_s2m_t lsu_r_s2m,
  input  axi_w_m2s_t lsu_w_m2s,
  output axi_w_s2m_t lsu_w_s2m,

  output axi_r_m2s_t clint_r_m2s,
  input  axi_r_s2m_t clint_r_s2m,

  output axi_r_m2s_t sram_r_m2s,
  input  axi_r_s2m_t sram_r_s2m,
  output axi_w_m2s_t sram_w_m2s,
  input  axi_w_s2m_t sram_w_s2m
);

  xbar_state_t state_q;
  xbar_state_t state_d;

  // request of the granted master, after masking
  axi_r_m2s_t gnt_r_m2s;
  // response of the selected slave
  axi_r_s2m_t sel_r_s2m;

  logic to_clint;
  logic last_fire;

  // grant register
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= xbar_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // fixed priority, fetch wins in idle
  // grant held until the rlast beat is taken
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      xbar_idle: begin
        if (ifu_r_m2s.arvalid) begin
          state_d = xbar_ifu_read;
        end else if (lsu_r_m2s.arvalid) begin
          state_d = xbar_lsu_read;
        end
      end
      xbar_ifu_read: begin
        if (last_fire) begin
          // hand over to load/store if it waits
          state_d = lsu_r_m2s.arvalid ? xbar_lsu_read : xbar_idle;
        end
      end
      xbar_lsu_read: begin
        if (last_fire) begin
          state_d = ifu_r_m2s.arvalid ? xbar_ifu_read : xbar_idle;
        end
      end
      default: begin
        state_d = xbar_idle;
      end
    endcase
  end

  // mux of the granted request
  // payload defaults to fetch, valid and ready killed in idle
  always_comb begin
    gnt_r_m2s = (state_q == xbar_lsu_read) ? lsu_r_m2s : ifu_r_m2s;
    if (state_q == xbar_idle) begin
      gnt_r_m2s.arvalid = 1'b0;
      gnt_r_m2s.rready  = 1'b0;
    end
  end

  // address decode, master holds araddr for the whole burst
  assign to_clint  = gnt_r_m2s.araddr < clint_limit;
  assign sel_r_s2m = to_clint ? clint_r_s2m : sram_r_s2m;

  // end of burst for the granted master
  assign last_fire = gnt_r_m2s.rready && sel_r_s2m.rvalid && sel_r_s2m.rlast;

  // requests to the slaves, only the selected one sees valid/ready
  always_comb begin
    clint_r_m2s = gnt_r_m2s;
    sram_r_m2s  = gnt_r_m2s;
    if (to_clint) begin
      sram_r_m2s.arvalid = 1'b0;
      sram_r_m2s.rready  = 1'b0;
    end else begin
      clint_r_m2s.arvalid = 1'b0;
      clint_r_m2s.rready  = 1'b0;
    end
  end

  // responses back, masters without the grant see no handshake
  always_comb begin
    ifu_r_s2m = sel_r_s2m;
    lsu_r_s2m = sel_r_s2m;
    if (state_q != xbar_ifu_read) begin
      ifu_r_s2m.arready = 1'b0;
      ifu_r_s2m.rvalid  = 1'b0;
    end
    if (state_q != xbar_lsu_read) begin
      lsu_r_s2m.arready = 1'b0;
      lsu_r_s2m.rvalid  = 1'b0;
    end
  end

  // all writes go to sram, no clint write port
  assign sram_w_m2s = lsu_w_m2s;
  assign lsu_w_s2m  = sram_w_s2m;

endmodule

/* mem_subsys.sv */
`timescale 1ns/10ps

module mem_subsys
  import axi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,

  // fetch read master
  input  axi_r_m2s_t ifu_r_m2s,
  output axi_r_s2m_t ifu_r_s2m,

  // load/store masters, read and write
  input  axi_r_m2s_t lsu_r_m2s,
  output axi_r_s2m_t lsu_r_s2m,
  input  axi_w_m2s_t lsu_w_m2s,
  output axi_w_s2m_t lsu_w_s2m
);

  // slave side links
  axi_r_m2s_t clint_r_m2s;
  axi_r_s2m_t clint_r_s2m;
  axi_r_m2s_t sram_r_m2s;
  axi_r_s2m_t sram_r_s2m;
  axi_w_m2s_t sram_w_m2s;
  axi_w_s2m_t sram_w_s2m;

  // arbiter, decoder and write path
  axi_interconnect i_axi_interconnect (
    .clock       (clock),
    .reset       (reset),
    .ifu_r_m2s   (ifu_r_m2s),
    .ifu_r_s2m   (ifu_r_s2m),
    .lsu_r_m2s   (lsu_r_m2s),
    .lsu_r_s2m   (lsu_r_s2m),
    .lsu_w_m2s   (lsu_w_m2s),
    .lsu_w_s2m   (lsu_w_s2m),
    .clint_r_m2s (clint_r_m2s),
    .clint_r_s2m (clint_r_s2m),
    .sram_r_m2s  (sram_r_m2s),
    .sram_r_s2m  (sram_r_s2m),
    .sram_w_m2s  (sram_w_m2s),
    .sram_w_s2m  (sram_w_s2m)
  );

  // timer, read only
  clint i_clint (
    .clock (clock),
    .reset (reset),
    .r_m2s (clint_r_m2s),
    .r_s2m (clint_r_s2m)
  );

  // main memory
  axi_sram i_axi_sram (
    .clock (clock),
    .reset (reset),
    .r_m2s (sram_r_m2s),
    .r_s2m (sram_r_s2m),
    .w_m2s (sram_w_m2s),
    .w_s2m (sram_w_s2m)
  );

endmodule

/* mem_subsys_chk.sv */
`timescale 1ns/10ps

module mem_subsys_chk
  import axi_pkg::*;
(
  input logic        clock,
  input logic        reset,
  input axi_r_m2s_t  ifu_r_m2s,
  input axi_r_s2m_t  ifu_r_s2m,
  input axi_r_m2s_t  lsu_r_m2s,
  input axi_r_s2m_t  lsu_r_s2m,
  input axi_w_m2s_t  lsu_w_m2s,
  input axi_w_s2m_t  lsu_w_s2m,
  input xbar_state_t state_q
);

  // failed assertions so far, summed into the final verdict
  int fail_count = 0;

  // ar request held until accepted
  assert property (@(posedge clock) disable iff (reset)
    ifu_r_m2s.arvalid && !ifu_r_s2m.arready |=>
      ifu_r_m2s.arvalid && $stable(ifu_r_m2s.araddr) && $stable(ifu_r_m2s.arlen))
    else begin
      $error("fetch ar request changed before arready");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (reset)
    lsu_r_m2s.arvalid && !lsu_r_s2m.arready |=>
      lsu_r_m2s.arvalid && $stable(lsu_r_m2s.araddr) && $stable(lsu_r_m2s.arlen))
    else begin
      $error("load/store ar request changed before arready");
      fail_count++;
    end

  // read beats held under back-pressure
  assert property (@(posedge clock) disable iff (reset)
    ifu_r_s2m.rvalid && !ifu_r_m2s.rready |=>
      ifu_r_s2m.rvalid && $stable(ifu_r_s2m.rdata) && $stable(ifu_r_s2m.rlast))
    else begin
      $error("fetch read beat changed before rready");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (reset)
    lsu_r_s2m.rvalid && !lsu_r_m2s.rready |=>
      lsu_r_s2m.rvalid && $stable(lsu_r_s2m.rdata) && $stable(lsu_r_s2m.rlast))
    else begin
      $error("load/store read beat changed before rready");
      fail_count++;
    end

  // aw and w go together
  assert property (@(posedge clock) disable iff (reset)
    lsu_w_m2s.awvalid && !lsu_w_s2m.awready |=>
      lsu_w_m2s.awvalid && lsu_w_m2s.wvalid && $stable(lsu_w_m2s.awaddr) &&
      $stable(lsu_w_m2s.wdata) && $stable(lsu_w_m2s.wstrb))
    else begin
      $error("write request changed before awready");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (reset)
    lsu_w_s2m.bvalid && !lsu_w_m2s.bready |=> lsu_w_s2m.bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  // one read master at a time
  assert property (@(posedge clock) disable iff (reset)
    !(ifu_r_s2m.rvalid && lsu_r_s2m.rvalid))
    else begin
      $error("both read masters see rvalid");
      fail_count++;
    end

  // grant moves only from idle or after the rlast beat seen by its master
  assert property (@(posedge clock) disable iff (reset)
    state_q == xbar_ifu_read &&
    !(ifu_r_s2m.rvalid && ifu_r_m2s.rready && ifu_r_s2m.rlast) |=> $stable(state_q))
    else begin
      $error("grant left fetch inside a burst");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (reset)
    state_q == xbar_lsu_read &&
    !(lsu_r_s2m.rvalid && lsu_r_m2s.rready && lsu_r_s2m.rlast) |=> $stable(state_q))
    else begin
      $error("grant left load/store inside a burst");
      fail_count++;
    end

endmodule

bind axi_interconnect mem_subsys_chk i_mem_subsys_chk (
  .clock     (clock),
  .reset     (reset),
  .ifu_r_m2s (ifu_r_m2s),
  .ifu_r_s2m (ifu_r_s2m),
  .lsu_r_m2s (lsu_r_m2s),
  .lsu_r_s2m (lsu_r_s2m),
  .lsu_w_m2s (lsu_w_m2s),
  .lsu_w_s2m (lsu_w_s2m),
  .state_q   (state_q)
);

/* mem_subsys_scoreboard.sv */
`timescale 1ns/10ps

module mem_subsys_scoreboard
  import axi_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input axi_r_m2s_t ifu_r_m2s,
  input axi_r_s2m_t ifu_r_s2m,
  input axi_r_m2s_t lsu_r_m2s,
  input axi_r_s2m_t lsu_r_s2m,
  input axi_w_m2s_t lsu_w_m2s,
  input axi_w_s2m_t lsu_w_s2m
);

  localparam int max_lines = 64;
  localparam int cols = 7;

  // one expected read beat
  typedef struct packed {
    logic [31:0] data;
    logic        last;
    logic        rising;
  } beat_t;

  logic [31:0] stim [max_lines*cols];
  beat_t       ifu_q [$];
  beat_t       lsu_q [$];
  logic        open [2];
  // read request seen, its rlast beat not taken yet
  logic        pending [2];
  int          req_cycle [2];
  int          cycle;
  logic [31:0] clint_prev;
  int          rem [2];
  int          errors;
  int          checks;
  int          mark;
  int          tests;
  int          writes_expected;
  int          b_count;

  // expected beats per master, in file order
  initial begin
    beat_t b;
    int    m;
    errors = 0;
    checks = 0;
    mark = 0;
    tests = 0;
    writes_expected = 0;
    b_count = 0;
    cycle = 0;
    clint_prev = '0;
    open[0] = 1'b0;
    open[1] = 1'b0;
    pending[0] = 1'b0;
    pending[1] = 1'b0;
    req_cycle[0] = 0;
    req_cycle[1] = 0;
    for (int i = 0; i < max_lines*cols; i++) begin
      stim[i] = '1;
    end
    $readmemh("mem_subsys_stim.txt", stim);
    for (int i = 0; i < max_lines && stim[i*cols] != 32'hffff_ffff; i++) begin
      m = stim[i*cols+1];
      b.data = stim[i*cols+6];
      b.rising = 1'b0;
      b.last = 1'b0;
      case (stim[i*cols+2])
        0: writes_expected++;
        1: begin
          rem[m] = stim[i*cols+4];
          b.last = rem[m] == 0;
        end
        2: begin
          rem[m]--;
          b.last = rem[m] == 0;
        end
        3: begin
          b.rising = 1'b1;
          b.last = 1'b1;
        end
        default: ;
      endcase
      if (stim[i*cols+2] inside {1, 2, 3}) begin
        if (m == 0) begin
          ifu_q.push_back(b);
        end else begin
          lsu_q.push_back(b);
        end
      end
    end
  end

  task automatic check_beat(input int m, input logic [31:0] data, input logic last);
    beat_t exp;
    string name;
    int    n;
    name = (m == 0) ? "ifu_r_s2m" : "lsu_r_s2m";
    n = (m == 0) ? ifu_q.size() : lsu_q.size();
    // bursts must stay contiguous
    if (open[1-m]) begin
      $display("%s beat arrived inside a burst of the other master", name);
      errors++;
    end
    // fetch wins a tie, otherwise the older request goes first
    if (pending[1-m] && (req_cycle[1-m] < req_cycle[m] ||
                         (req_cycle[1-m] == req_cycle[m] && m == 1))) begin
      $display("%s beat served ahead of a read request with priority", name);
      errors++;
    end
    if (n == 0) begin
      $display("read beat on %s with no read outstanding", name);
      errors++;
    end else begin
      exp = (m == 0) ? ifu_q.pop_front() : lsu_q.pop_front();
      checks++;
      if (exp.rising) begin
        // timer only moves forward
        if (data <= clint_prev) begin
          $display("error %s.rdata expected above %h got %h", name, clint_prev, data);
          errors++;
        end
        clint_prev = data;
      end else if (data !== exp.data) begin
        $display("error %s.rdata expected %h got %h", name, exp.data, data);
        errors++;
      end
      if (last !== exp.last) begin
        $display("error %s.rlast expected %h got %h", name, exp.last, last);
        errors++;
      end
    end
    open[m] = !last;
    if (last) begin
      pending[m] = 1'b0;
    end
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      cycle++;
      if (ifu_r_s2m.rvalid && ifu_r_m2s.rready) begin
        check_beat(0, ifu_r_s2m.rdata, ifu_r_s2m.rlast);
      end
      if (lsu_r_s2m.rvalid && lsu_r_m2s.rready) begin
        check_beat(1, lsu_r_s2m.rdata, lsu_r_s2m.rlast);
      end
      if (lsu_w_s2m.bvalid && lsu_w_m2s.bready) begin
        b_count++;
      end
      // aw and w accepted in the same cycle
      if (lsu_w_s2m.wready !== lsu_w_s2m.awready) begin
        $display("error lsu_w_s2m.wready expected %h got %h",
                 lsu_w_s2m.awready, lsu_w_s2m.wready);
        errors++;
      end
      // age of a request counts from its first arvalid
      if (ifu_r_m2s.arvalid && !pending[0]) begin
        pending[0] = 1'b1;
        req_cycle[0] = cycle;
      end
      if (lsu_r_m2s.arvalid && !pending[1]) begin
        pending[1] = 1'b1;
        req_cycle[1] = cycle;
      end
    end
  end

  task automatic finish_test(input int t);
    tests++;
    if (errors == mark) begin
      $display("test %0d done, ok", t);
    end else begin
      $display("test %0d done, %0d errors", t, errors - mark);
    end
    mark = errors;
  endtask

  task automatic report(input int assert_fails);
    if (ifu_q.size() != 0 || lsu_q.size() != 0) begin
      $display("read beats never arrived: %0d fetch, %0d load/store",
               ifu_q.size(), lsu_q.size());
      errors++;
    end
    if (b_count != writes_expected) begin
      $display("write responses missing: %0d writes but %0d responses",
               writes_expected, b_count);
      errors++;
    end
    if (assert_fails != 0) begin
      $display("protocol assertions failed %0d times", assert_fails);
      errors += assert_fails;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
  endtask

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/10ps

module tb_mem_subsys
  import axi_pkg::*;
();

  localparam int max_lines = 64;
  localparam int cols = 7;

  logic        clock;
  logic        reset;
  axi_r_m2s_t  r_m2s [2];
  axi_r_s2m_t  r_s2m [2];
  axi_w_m2s_t  w_m2s;
  axi_w_s2m_t  w_s2m;
  logic [31:0] stim [max_lines*cols];
  logic [31:0] lcg_state;
  int          n_lines;
  int          limit;
  logic        limit_ready;

  mem_subsys i_mem_subsys (
    .clock     (clock),
    .reset     (reset),
    .ifu_r_m2s (r_m2s[0]),
    .ifu_r_s2m (r_s2m[0]),
    .lsu_r_m2s (r_m2s[1]),
    .lsu_r_s2m (r_s2m[1]),
    .lsu_w_m2s (w_m2s),
    .lsu_w_s2m (w_s2m)
  );

  mem_subsys_scoreboard i_scoreboard (
    .clock     (clock),
    .reset     (reset),
    .ifu_r_m2s (r_m2s[0]),
    .ifu_r_s2m (r_s2m[0]),
    .lsu_r_m2s (r_m2s[1]),
    .lsu_r_s2m (r_s2m[1]),
    .lsu_w_m2s (w_m2s),
    .lsu_w_s2m (w_s2m)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  end

  // lcg, ready low about one cycle in four
  function automatic logic next_ready();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[17:16] != 2'b00;
  endfunction

  // called just after a rising edge, returns after rlast is taken
  task automatic read_op(input int m, input logic [31:0] addr, input logic [31:0] len);
    logic done;
    r_m2s[m].arvalid <= 1'b1;
    r_m2s[m].araddr  <= addr;
    r_m2s[m].arlen   <= len[7:0];
    r_m2s[m].arsize  <= 3'd2;
    r_m2s[m].arburst <= burst_incr;
    r_m2s[m].rready  <= 1'b1;
    do begin
      @(posedge clock);
    end while (!r_s2m[m].arready);
    r_m2s[m].arvalid <= 1'b0;
    // araddr held to the end, decode needs it
    done = 1'b0;
    while (!done) begin
      @(posedge clock);
      if (r_s2m[m].rvalid && r_m2s[m].rready && r_s2m[m].rlast) begin
        done = 1'b1;
      end else begin
        r_m2s[m].rready <= next_ready();
      end
    end
    r_m2s[m].rready <= 1'b0;
  endtask

  task automatic write_op(input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] strb);
    logic done;
    w_m2s.awvalid <= 1'b1;
    w_m2s.awaddr  <= addr;
    w_m2s.awlen   <= 8'd0;
    w_m2s.awsize  <= 3'd2;
    w_m2s.awburst <= burst_incr;
    w_m2s.wvalid  <= 1'b1;
    w_m2s.wdata   <= data;
    w_m2s.wstrb   <= strb[strb_w-1:0];
    w_m2s.wlast   <= 1'b1;
    w_m2s.bready  <= next_ready();
    do begin
      @(posedge clock);
    end while (!(w_s2m.awready && w_s2m.wready));
    w_m2s.awvalid <= 1'b0;
    w_m2s.wvalid  <= 1'b0;
    done = 1'b0;
    while (!done) begin
      @(posedge clock);
      if (w_s2m.bvalid && w_m2s.bready) begin
        done = 1'b1;
      end else begin
        w_m2s.bready <= next_ready();
      end
    end
    w_m2s.bready <= 1'b0;
  endtask

  // all operations of one master in one test, in file order
  task automatic run_master(input int m, input logic [31:0] t);
    for (int i = 0; i < n_lines; i++) begin
      logic [31:0] kind;
      kind = stim[i*cols+2];
      if (stim[i*cols] == t && stim[i*cols+1] == m) begin
        case (kind)
          0: write_op(stim[i*cols+3], stim[i*cols+6], stim[i*cols+5]);
          1, 3: read_op(m, stim[i*cols+3], stim[i*cols+4]);
          5: repeat (stim[i*cols+4]) @(posedge clock);
          default: ;
        endcase
      end
    end
  endtask

  initial begin
    logic [31:0] tests [$];
    logic [31:0] t;
    int          beats;
    lcg_state = 32'h2246fc84;
    limit_ready = 1'b0;
    r_m2s[0] = '0;
    r_m2s[1] = '0;
    w_m2s = '0;
    for (int i = 0; i < max_lines*cols; i++) begin
      stim[i] = '1;
    end
    $readmemh("mem_subsys_stim.txt", stim);
    n_lines = 0;
    while (n_lines < max_lines && stim[n_lines*cols] != 32'hffff_ffff) begin
      n_lines++;
    end
    // test ids in order of first use, beats per test for the limit
    limit = 100;
    for (int i = 0; i < n_lines; i++) begin
      if (tests.size() == 0 || tests[tests.size()-1] != stim[i*cols]) begin
        tests.push_back(stim[i*cols]);
        limit += 4 * 8;
      end
      beats = (stim[i*cols+2] == 5) ? stim[i*cols+4] : 1;
      limit += beats * 8;
    end
    limit_ready = 1'b1;
    wait (reset == 1'b0);
    @(posedge clock);
    foreach (tests[k]) begin
      t = tests[k];
      fork
        run_master(0, t);
        run_master(1, t);
      join
      @(negedge clock);
      i_scoreboard.finish_test(t);
      @(posedge clock);
    end
    i_scoreboard.report(i_mem_subsys.i_axi_interconnect.i_mem_subsys_chk.fail_count);
    if (i_scoreboard.errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    int cycles;
    cycles = 0;
    wait (limit_ready);
    while (cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* mem_subsys_stim.txt */
// columns: test master kind addr len strb data, all hex
// master 0 fetch 1 load/store; kind 0 write 1 read 2 next beat 3 clint rising 5 idle cycles
1 1 0 80000000 0 f 11223344
1 1 0 80000004 0 5 aabbccdd
1 1 1 80000004 0 0 00bb00dd
1 1 1 80000000 0 0 11223344
2 1 0 80000010 0 f 10000001
2 1 0 80000014 0 f 20000002
2 1 0 80000018 0 f 30000003
2 1 0 8000001c 0 f 40000004
2 1 0 80000014 0 c 5566ffff
3 0 1 80000010 3 0 10000001
3 0 2 00000000 0 0 55660002
3 0 2 00000000 0 0 30000003
3 0 2 00000000 0 0 40000004
4 0 1 80000018 1 0 30000003
4 0 2 00000000 0 0 40000004
4 1 1 80000000 0 0 11223344
5 1 1 80000010 3 0 10000001
5 1 2 00000000 0 0 55660002
5 1 2 00000000 0 0 30000003
5 1 2 00000000 0 0 40000004
5 0 5 00000000 3 0 00000000
5 0 1 80000004 0 0 00bb00dd
6 1 3 02000000 0 0 00000000
6 1 3 02000000 0 0 00000000
6 1 1 02000004 0 0 00000000
7 1 0 80000040 0 f cafef00d
7 1 1 80000440 0 0 cafef00d
7 0 5 00000000 14 0 00000000
7 0 1 80000840 0 0 cafef00d
8 0 1 80000100 0 0 00000000
8 1 1 80000104 0 0 00000000

/* verilog.f */
axi_pkg.sv
clint.sv
axi_sram.sv
axi_interconnect.sv
mem_subsys.sv
mem_subsys_chk.sv
mem_subsys_scoreboard.sv
tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - axi_pkg.sv
  - clint.sv
  - axi_sram.sv
  - axi_interconnect.sv
  - mem_subsys.sv
  - target: test
    files:
      - mem_subsys_chk.sv
      - mem_subsys_scoreboard.sv
      - tb_mem_subsys.sv
